/* booth_mult.f */
+incdir+source
source/booth_mult_pkg.sv
source/booth_controller.sv
source/booth_step_decode.sv
source/booth_datapath.sv
source/booth_result.sv
source/booth_mult_top.sv
test/tb_booth_mult.sv

/* Makefile */
# Verilator simulation of the Booth multiplier

VERILATOR ?= verilator
TOP       ?= tb_booth_mult
FILELIST  ?= booth_mult.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(wildcard source/*.sv source/*.svh test/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_booth_mult.sv */
`timescale 1ns/100ps
`default_nettype none

`include "booth_mult_config.svh"

module tb_booth_mult
    import booth_mult_pkg::*;
();

    localparam int W            = `BOOTH_WIDTH;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 3;
    localparam int N_CORNER     = 12;
    localparam int N_RANDOM     = 300;
    localparam int STALL_MARGIN = 8;

    logic     clk;
    logic     rst_n;
    logic     src_valid;
    logic     src_ready;
    operand_t multiplicand;
    operand_t multiplier;
    logic     dest_valid;
    logic     dest_ready;
    product_t product;

    product_t expected_q[$];     // Products still owed by the DUT
    operand_t corner_a[$];
    operand_t corner_b[$];
    int       errors   = 0;
    int       accepted = 0;
    int       received = 0;
    int       busy_left = 0;     // Cycles src_ready must still stay low
    logic     hold_prev = 1'b0;  // Last cycle was a stalled destination
    product_t held_product;

    booth_mult_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .src_valid    (src_valid),
        .src_ready    (src_ready),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .dest_valid   (dest_valid),
        .dest_ready   (dest_ready),
        .product      (product)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reference model of a signed multiply
    function automatic product_t signed_product(input operand_t a, input operand_t b);
        product_t wide_a;
        product_t wide_b;
        wide_a = product_t'(a); // Sign extension
        wide_b = product_t'(b);
        return wide_a * wide_b;
    endfunction

    task automatic compare_value(input string name, input product_t got, input product_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic queue_pair(input operand_t a, input operand_t b);
        corner_a.push_back(a);
        corner_b.push_back(b);
    endtask

    // Offer one pair, hold it until accepted, then idle for gap cycles
    task automatic send_pair(input operand_t a, input operand_t b, input int gap);
        logic taken;
        src_valid    = 1'b1;
        multiplicand = a;
        multiplier   = b;
        do begin
            @(negedge clk);
            taken = src_ready;
            @(posedge clk);
            #2;
        end while (!taken);
        src_valid = 1'b0;
        repeat (gap) begin
            multiplicand = operand_t'($urandom); // Ignored while not valid
            multiplier   = operand_t'($urandom);
            @(posedge clk);
            #2;
        end
    endtask

    // Random dest_ready with occasional long stalls
    initial begin
        int stall_left;
        stall_left = 0;
        forever begin
            @(posedge clk);
            #2;
            if (stall_left > 0) begin
                dest_ready = 1'b0;
                stall_left--;
            end else if ($urandom % 16 == 0) begin
                dest_ready = 1'b0;
                stall_left = 5 + $urandom % 20;
            end else begin
                dest_ready = ($urandom % 4) != 0;
            end
        end
    end

    // Handshakes sampled mid-cycle complete at the next rising edge
    always @(negedge clk) begin
        product_t expected;
        if (rst_n) begin
            if (hold_prev) begin
                compare_value("dest_valid", dest_valid, 1'b1);
                compare_value("product", product, held_product);
            end
            hold_prev    = dest_valid && !dest_ready;
            held_product = product;
            if (busy_left > 0) begin
                compare_value("src_ready", src_ready, 1'b0);
                busy_left--;
            end
            if (src_valid && src_ready) begin
                expected_q.push_back(signed_product(multiplicand, multiplier));
                accepted++;
                busy_left = W + 1; // W cycles of RUN plus at least one of DONE
            end
            if (dest_valid && dest_ready) begin
                received++;
                if (expected_q.size() == 0) begin
                    $display("%0t: product delivered with no operand pair waiting", $time);
                    errors++;
                end else begin
                    expected = expected_q.pop_front();
                    compare_value("product", product, expected);
                end
            end
        end
    end

    initial begin
        operand_t min_val;
        operand_t alt_01;
        operand_t alt_10;
        int       i;
        void'($urandom(32'h7e910af6));
        rst_n        = 1'b0;
        src_valid    = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        dest_ready   = 1'b0;
        min_val = operand_t'(1) << (W - 1);
        for (i = 0; i < W; i++) begin
            alt_01[i] = i[0];
            alt_10[i] = !i[0];
        end
        queue_pair(min_val, min_val);
        queue_pair(min_val, operand_t'(-1));
        queue_pair(operand_t'(-1), min_val);
        queue_pair(operand_t'(0), operand_t'($urandom));
        queue_pair(operand_t'($urandom), operand_t'(0));
        queue_pair(alt_01, alt_10);
        queue_pair(alt_10, alt_01);
        queue_pair(alt_01, alt_01);
        queue_pair(alt_10, alt_10);
        queue_pair(~min_val, ~min_val); // Largest positive value
        queue_pair(~min_val, min_val);
        queue_pair(operand_t'(1), operand_t'(-1));

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("src_ready", src_ready, 1'b1);
        compare_value("dest_valid", dest_valid, 1'b0);
        @(posedge clk);
        #2;

        for (i = 0; i < N_CORNER; i++) begin
            send_pair(corner_a[i], corner_b[i], $urandom % 4);
        end
        for (i = 0; i < N_RANDOM; i++) begin
            send_pair(operand_t'($urandom), operand_t'($urandom), $urandom % 4);
        end

        wait (received == N_CORNER + N_RANDOM);
        repeat (4 * (W + 2)) @(posedge clk); // Catch duplicated products
        if (expected_q.size() != 0) begin
            $display("%0d expected products never arrived", expected_q.size());
            errors++;
        end
        if (received != accepted) begin
            $display("accepted pairs and received products do not match");
            errors++;
        end
        $display("errors: %0d, pairs accepted: %0d, products received: %0d",
                 errors, accepted, received);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog allows W+2 cycles per test times the stall margin
    initial begin
        #(((N_CORNER + N_RANDOM) * (W + 2) * STALL_MARGIN + RESET_CYCLES + 2) * CLK_PERIOD);
        $display("simulation stopped by watchdog, %0d of %0d products received",
                 received, N_CORNER + N_RANDOM);
        $display("errors: %0d, pairs accepted: %0d, products received: %0d",
                 errors, accepted, received);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* source/booth_mult_top.sv */
`timescale 1ns/100ps
`default_nettype none

module booth_mult_top
    import booth_mult_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     src_valid,
    output logic     src_ready,
    input  operand_t multiplicand,
    input  operand_t multiplier,

    output logic     dest_valid,
    input  logic     dest_ready,
    output product_t product
);

    logic     load;
    logic     step_en;
    logic     result_load;
    logic     count_done;
    logic     result_free;
    logic     q0;
    logic     q_extra;
    alu_op_t  alu_op;
    product_t product_value;

    booth_controller i_controller (
        .clk         (clk),
        .rst_n       (rst_n),
        .src_valid   (src_valid),
        .src_ready   (src_ready),
        .count_done  (count_done),
        .result_free (result_free),
        .load        (load),
        .step_en     (step_en),
        .result_load (result_load)
    );

    booth_step_decode i_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .step_en    (step_en),
        .q0         (q0),
        .q_extra    (q_extra),
        .alu_op     (alu_op),
        .count_done (count_done)
    );

    booth_datapath i_datapath (
        .clk           (clk),
        .rst_n         (rst_n),
        .load          (load),
        .step_en       (step_en),
        .multiplicand  (multiplicand),
        .multiplier    (multiplier),
        .alu_op        (alu_op),
        .q0            (q0),
        .q_extra       (q_extra),
        .product_value (product_value)
    );

    booth_result i_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .result_load   (result_load),
        .product_value (product_value),
        .result_free   (result_free),
        .dest_valid    (dest_valid),
        .dest_ready    (dest_ready),
        .product       (product)
    );

endmodule

`default_nettype wire

/* source/booth_result.sv */
`timescale 1ns/100ps
`default_nettype none

module booth_result
    import booth_mult_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     result_load,   // Finished product from execute
    input  product_t product_value,
    output logic     result_free,   // Empty or draining this cycle

    output logic     dest_valid,
    input  logic     dest_ready,
    output product_t product
);

    // Holding register written only on handover
    always_ff @(posedge clk) begin
        if (result_load) begin
            product <= product_value;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dest_valid <= 1'b0;
        end else if (result_load) begin
            dest_valid <= 1'b1;
        end else if (dest_ready) begin
            dest_valid <= 1'b0; // Transfer completed or nothing held
        end
    end

    assign result_free = !dest_valid || dest_ready;

    // Destination sees a stable product under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        (dest_valid && !dest_ready) |=> (dest_valid && $stable(product)))
        else $error("product changed while waiting for dest_ready");

endmodule

`default_nettype wire

/* source/booth_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

`include "booth_mult_config.svh"

module booth_datapath
    import booth_mult_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     load,
    input  logic     step_en,

    input  operand_t multiplicand,
    input  operand_t multiplier,
    input  alu_op_t  alu_op,

    output logic     q0,
    output logic     q_extra,
    output product_t product_value
);

    localparam int W = `BOOTH_WIDTH;

    // Accumulator carries one guard bit so that M = min can be subtracted
    logic signed [W:0]   acc;
    logic signed [W:0]   m_ext;
    logic signed [W:0]   sum;
    operand_t            m_reg;
    operand_t            q_reg;
    logic                extra_bit;
    logic signed [2*W+1:0] shifted;

    assign m_ext = {m_reg[W-1], m_reg}; // Sign extended multiplicand

    always_comb begin
        case (alu_op)
            ALU_ADD: sum = acc + m_ext;
            ALU_SUB: sum = acc - m_ext;
            default: sum = acc;
        endcase
    end

    // Arithmetic right shift of {A, Q, Q-1}
    assign shifted = $signed({sum, q_reg, extra_bit}) >>> 1;

    always_ff @(posedge clk) begin
        if (load) begin
            m_reg <= multiplicand;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            q_reg     <= '0;
            extra_bit <= 1'b0;
        end else if (load) begin
            acc       <= '0;
            q_reg     <= multiplier;
            extra_bit <= 1'b0;
        end else if (step_en) begin
            acc       <= shifted[2*W+1:W+1];
            q_reg     <= shifted[W:1];
            extra_bit <= shifted[0];
        end
    end

    assign q0      = q_reg[0];
    assign q_extra = extra_bit;

    // Guard bit dropped, the product fits in 2W bits
    assign product_value = {acc[W-1:0], q_reg};

endmodule

`default_nettype wire

/* source/booth_step_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "booth_mult_config.svh"

module booth_step_decode
    import booth_mult_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    input  logic    load,       // New operand pair
    input  logic    step_en,    // Step taken this cycle

    input  logic    q0,         // Multiplier LSB
    input  logic    q_extra,    // Bit shifted out on the previous step

    output alu_op_t alu_op,
    output logic    count_done
);

    step_count_t step_count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_count <= '0;
        end else if (load) begin
            step_count <= step_count_t'(`BOOTH_WIDTH);
        end else if (step_en) begin
            step_count <= step_count - 1'b1;
        end
    end

    // Counter reaches zero at the end of this step
    assign count_done = (step_count == step_count_t'(1));

    // Radix-2 recoding of the current bit pair
    always_comb begin
        case ({q0, q_extra})
            2'b10:   alu_op = ALU_SUB;  // Start of a run of ones
            2'b01:   alu_op = ALU_ADD;  // End of a run of ones
            default: alu_op = ALU_NOP;
        endcase
    end

    // Controller must stop stepping once the count is used up
    assert property (@(posedge clk) disable iff (!rst_n)
        step_en |-> (step_count != '0))
        else $error("step_en with exhausted step counter");

endmodule

`default_nettype wire

/* source/booth_controller.sv */
`timescale 1ns/100ps
`default_nettype none

`include "booth_mult_config.svh"

module booth_controller
    import booth_mult_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    input  logic src_valid,   // Operand pair offered
    output logic src_ready,   // Only high in IDLE

    input  logic count_done,  // Last Booth step in progress
    input  logic result_free, // Holding register can take a product

    output logic load,        // Capture operands, clear accumulator
    output logic step_en,     // One add/sub plus shift
    output logic result_load  // Move product into the holding register
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (src_valid) begin
                    next_state = RUN; // Operands accepted this edge
                end
            end
            RUN: begin
                if (count_done) begin
                    next_state = DONE;
                end
            end
            DONE: begin
                // Stay here while the previous product is still waiting
                if (result_free) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    assign src_ready   = (state == IDLE);
    assign load        = src_ready && src_valid;         // Source transfer
    assign step_en     = (state == RUN);
    assign result_load = (state == DONE) && result_free;

    // A step never overlaps the operand capture
    assert property (@(posedge clk) disable iff (!rst_n)
        !(load && step_en))
        else $error("load and step_en high together");

    // Accepted pair gives exactly BOOTH_WIDTH steps, then DONE
    assert property (@(posedge clk) disable iff (!rst_n)
        load |=> step_en [*`BOOTH_WIDTH] ##1 (state == DONE && !step_en))
        else $error("step sequence length differs from BOOTH_WIDTH");

    // Handover only out of DONE and straight back to IDLE
    assert property (@(posedge clk) disable iff (!rst_n)
        result_load |-> (state == DONE) ##1 (state == IDLE))
        else $error("result_load outside DONE");

endmodule

`default_nettype wire

/* source/booth_mult_pkg.sv */
`default_nettype none

`include "booth_mult_config.svh"

package booth_mult_pkg;

    typedef logic signed [`BOOTH_WIDTH-1:0]   operand_t;    // Two's-complement operand
    typedef logic signed [2*`BOOTH_WIDTH-1:0] product_t;    // Double-width product
    typedef logic [`BOOTH_COUNT_W-1:0]        step_count_t; // Remaining Booth steps

    // Recoded operation for one Booth step
    typedef enum logic [1:0] {
        ALU_NOP = 2'b00,
        ALU_SUB = 2'b01,
        ALU_ADD = 2'b10
    } alu_op_t;

    typedef enum logic [1:0] {
        IDLE = 2'b00, // Waiting for operands
        RUN  = 2'b01, // Booth steps in progress
        DONE = 2'b10  // Product ready for the result stage
    } ctrl_state_t;

endpackage

`default_nettype wire

/* source/booth_mult_config.svh */
`ifndef BOOTH_MULT_CONFIG_SVH
`define BOOTH_MULT_CONFIG_SVH

// Operand width in bits, product is twice this
`define BOOTH_WIDTH 8

// Step counter has to hold the value BOOTH_WIDTH itself
`define BOOTH_COUNT_W ($clog2(`BOOTH_WIDTH + 1))

`endif
